// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal
TOP       ?= tb_az_acq_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Everything OK

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: az_acq_chk.sv
`timescale 1ns/10ps
`default_nettype none

module az_acq_chk (
  input  wire                                    clk,
  input  wire                                    reset_n,
  input  wire  [az_cfg_pkg::PC_W-1:0]            sw_pc_ctl_i,
  input  wire  [az_cfg_pkg::AZMUX_W-1:0]         azmux_i,
  input  wire                                    adc_reset_n_i,
  input  wire                                    adc_measure_valid_i,
  input  wire                                    sample_done_i,
  input  wire                                    result_valid_i
);

  // azmux may only switch while the precharge switch sits on boot
  azmux_on_boot: assert property (@(posedge clk) disable iff (!reset_n)
    $changed(azmux_i) |-> (sw_pc_ctl_i == az_cfg_pkg::SW_PC_BOOT))
    else $error("azmux moved while sw_pc was off boot");

  // once released the adc stays out of reset until its valid pulse
  adc_release_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (adc_reset_n_i && !adc_measure_valid_i) |=> adc_reset_n_i)
    else $error("adc went back into reset before its valid pulse");

  // the accepted pulse puts the adc straight back into reset
  adc_reset_on_valid: assert property (@(posedge clk) disable iff (!reset_n)
    (adc_reset_n_i && adc_measure_valid_i) |=> !adc_reset_n_i)
    else $error("adc stayed released after its valid pulse");

  // every valid pulse from a released adc becomes a sample
  valid_gives_done: assert property (@(posedge clk) disable iff (!reset_n)
    (adc_measure_valid_i && adc_reset_n_i) |-> sample_done_i)
    else $error("valid pulse from the released adc was not taken as a sample");

  result_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
    result_valid_i |=> !result_valid_i)
    else $error("result valid held longer than one cycle");

endmodule

`default_nettype wire

// File: az_acq_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module az_acq_monitor (
  input  wire                                    clk,
  input  wire                                    reset_n,

  // test context from the testbench
  input  int                                     test_id_i,
  input  wire                                    check_reset_i,
  input  wire  [az_cfg_pkg::AZMUX_W-1:0]         exp_azmux_hi_i,
  input  wire  [az_cfg_pkg::AZMUX_W-1:0]         exp_azmux_lo_i,
  input  wire  [az_cfg_pkg::PC_W-1:0]            exp_pc_hi_i,

  // observed dut ports
  input  wire                                    adc_reset_n_i,
  input  wire                                    adc_measure_valid_i,
  input  wire  [az_cfg_pkg::ADC_W-1:0]           adc_count_i,
  input  wire  [az_cfg_pkg::PC_W-1:0]            sw_pc_ctl_i,
  input  wire  [az_cfg_pkg::AZMUX_W-1:0]         azmux_i,
  input  wire  [az_cfg_pkg::STATUS_W-1:0]        status_i,
  input  wire signed [az_cfg_pkg::RES_W-1:0]     result_i,
  input  wire                                    result_valid_i,
  input  wire  [az_cfg_pkg::MON_W-1:0]           monitor_i,

  output int                                     errors_o,
  output int                                     results_o,
  output int                                     pairs_o
);

  logic [az_cfg_pkg::ADC_W-1:0]          last_lo;
  logic                                  have_lo;
  logic                                  res_pend;
  logic signed [az_cfg_pkg::RES_W-1:0]   exp_res;
  logic                                  stat_pend;
  logic [az_cfg_pkg::STATUS_W-1:0]       exp_stat;
  logic                                  exp_kind_hi;
  logic [az_cfg_pkg::MON_W-1:0]          exp_mon;

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset_state";
      2:       return "default_results";
      3:       return "azmux_codes";
      4:       return "status_count";
      5:       return "run_stop_resume";
      default: return "setup";
    endcase
  endfunction

  // auto-zeroed value, hi count minus lo count, both unsigned
  function automatic logic signed [az_cfg_pkg::RES_W-1:0] ref_result(
    input logic [az_cfg_pkg::ADC_W-1:0] hi,
    input logic [az_cfg_pkg::ADC_W-1:0] lo
  );
    int diff;
    diff = int'(hi) - int'(lo);
    return diff[az_cfg_pkg::RES_W-1:0];
  endfunction

  task automatic mismatch(input string what, input int expv, input int actv);
    $display("[FAIL] %s %s expected %0d actual %0d", test_name(test_id_i), what, expv, actv);
    errors_o = errors_o + 1;
  endtask

  initial
  begin
    errors_o  = 0;
    results_o = 0;
    pairs_o   = 0;
  end

  //////////////////////////////////////////////////
  // compare on pre-edge values

  always @(posedge clk)
  begin
    if (!reset_n)
    begin
      have_lo     = 1'b0;
      res_pend    = 1'b0;
      stat_pend   = 1'b0;
      // first sample after reset is a hi sample
      exp_kind_hi = 1'b1;
    end
    else
    begin
      // one cycle after a hi with a lo before it, a result is due
      if (res_pend)
      begin
        if (!result_valid_i)
          mismatch("result_valid", 1, 0);
        else if (result_i !== exp_res)
          mismatch("result", int'(exp_res), int'(result_i));
        results_o = results_o + 1;
        res_pend  = 1'b0;
      end
      else if (result_valid_i)
      begin
        $display("result_valid pulsed with no hi sample before it in %s", test_name(test_id_i));
        errors_o = errors_o + 1;
      end

      if (stat_pend)
      begin
        if (status_i !== exp_stat)
          mismatch("status", int'(exp_stat), int'(status_i));
        stat_pend = 1'b0;
      end

      // probe bus, adc release on bit 0 and valid on bit 1
      exp_mon    = '0;
      exp_mon[0] = adc_reset_n_i;
      exp_mon[1] = adc_measure_valid_i;
      if (monitor_i !== exp_mon)
        mismatch("monitor", int'(exp_mon), int'(monitor_i));

      // switch codes seen by the adc while it converts
      // samples alternate hi and lo, a started pair always completes
      if (adc_reset_n_i)
      begin
        if (exp_kind_hi)
        begin
          if (azmux_i !== exp_azmux_hi_i)
            mismatch("azmux_hi", int'(exp_azmux_hi_i), int'(azmux_i));
          if (sw_pc_ctl_i !== exp_pc_hi_i)
            mismatch("sw_pc_hi", int'(exp_pc_hi_i), int'(sw_pc_ctl_i));
        end
        else
        begin
          if (azmux_i !== exp_azmux_lo_i)
            mismatch("azmux_lo", int'(exp_azmux_lo_i), int'(azmux_i));
          if (sw_pc_ctl_i !== az_cfg_pkg::SW_PC_BOOT)
            mismatch("sw_pc_lo", int'(az_cfg_pkg::SW_PC_BOOT), int'(sw_pc_ctl_i));
        end
      end

      if (adc_reset_n_i && adc_measure_valid_i)
      begin
        if (exp_kind_hi)
        begin
          exp_stat = {pairs_o[1:0], 1'b1};
          if (have_lo)
          begin
            exp_res  = ref_result(adc_count_i, last_lo);
            res_pend = 1'b1;
          end
        end
        else
        begin
          pairs_o  = pairs_o + 1;
          exp_stat = {pairs_o[1:0], 1'b0};
          last_lo  = adc_count_i;
          have_lo  = 1'b1;
        end
        stat_pend   = 1'b1;
        exp_kind_hi = !exp_kind_hi;
      end

      if (check_reset_i)
      begin
        if (adc_reset_n_i !== 1'b0)
          mismatch("adc_reset_no", 0, int'(adc_reset_n_i));
        if (sw_pc_ctl_i !== az_cfg_pkg::SW_PC_BOOT)
          mismatch("sw_pc", int'(az_cfg_pkg::SW_PC_BOOT), int'(sw_pc_ctl_i));
        if (azmux_i !== az_cfg_pkg::DEF_AZMUX_LO)
          mismatch("azmux", int'(az_cfg_pkg::DEF_AZMUX_LO), int'(azmux_i));
        if (status_i !== '0)
          mismatch("status", 0, int'(status_i));
      end
    end
  end

endmodule

`default_nettype wire

// File: az_acq_top.sv
`timescale 1ns/10ps
`default_nettype none

module az_acq_top (
  input  wire                                    clk,
  input  wire                                    reset_n,

  // config write port
  input  wire                                    cfg_we_i,
  input  az_types_pkg::az_reg_e                  cfg_addr_i,
  input  wire  [az_cfg_pkg::CFG_DATA_W-1:0]      cfg_wdata_i,

  // adc
  output logic                                   adc_reset_no,
  input  wire                                    adc_measure_valid_i,
  input  wire  [az_cfg_pkg::ADC_W-1:0]           adc_count_i,

  // analog controls
  output logic [az_cfg_pkg::PC_W-1:0]            sw_pc_ctl_o,
  output logic [az_cfg_pkg::AZMUX_W-1:0]         azmux_o,

  // status and results
  output logic [az_cfg_pkg::STATUS_W-1:0]        status_o,
  output logic signed [az_cfg_pkg::RES_W-1:0]    result_o,
  output logic                                   result_valid_o,
  output logic [az_cfg_pkg::MON_W-1:0]           monitor_o
);

  logic [az_cfg_pkg::CNT_W-1:0]    precharge_cnt;
  logic [az_cfg_pkg::AZMUX_W-1:0]  azmux_hi;
  logic [az_cfg_pkg::AZMUX_W-1:0]  azmux_lo;
  logic [az_cfg_pkg::PC_W-1:0]     pc_hi;
  logic                            run;
  logic                            sample_done;
  az_types_pkg::az_kind_e          sample_kind;

  // scope probe, adc release and valid on the two low bits
  assign monitor_o = {{(az_cfg_pkg::MON_W-2){1'b0}}, adc_measure_valid_i, adc_reset_no};

  az_cfg_regs i_az_cfg_regs (
    .clk             (clk),
    .reset_n         (reset_n),
    .cfg_we_i        (cfg_we_i),
    .cfg_addr_i      (cfg_addr_i),
    .cfg_wdata_i     (cfg_wdata_i),
    .precharge_cnt_o (precharge_cnt),
    .azmux_hi_o      (azmux_hi),
    .azmux_lo_o      (azmux_lo),
    .pc_hi_o         (pc_hi),
    .run_o           (run)
  );

  // led output is a board indicator, not brought out here
  az_sequencer i_az_sequencer (
    .clk                 (clk),
    .reset_n             (reset_n),
    .precharge_cnt_i     (precharge_cnt),
    .azmux_hi_i          (azmux_hi),
    .azmux_lo_i          (azmux_lo),
    .pc_hi_i             (pc_hi),
    .run_i               (run),
    .adc_measure_valid_i (adc_measure_valid_i),
    .adc_reset_no        (adc_reset_no),
    .sw_pc_ctl_o         (sw_pc_ctl_o),
    .azmux_o             (azmux_o),
    .sample_done_o       (sample_done),
    .sample_kind_o       (sample_kind),
    .status_o            (status_o),
    .led0_o              ()
  );

  az_result i_az_result (
    .clk            (clk),
    .reset_n        (reset_n),
    .sample_done_i  (sample_done),
    .sample_kind_i  (sample_kind),
    .adc_count_i    (adc_count_i),
    .result_o       (result_o),
    .result_valid_o (result_valid_o)
  );

endmodule

`default_nettype wire

// File: az_cfg_pkg.sv
`default_nettype none

package az_cfg_pkg;

  // adc count and result widths
  localparam int ADC_W      = 24;
  localparam int RES_W      = 25;

  // settle counter and config write data
  localparam int CNT_W      = 24;
  localparam int CFG_DATA_W = 24;

  // analog switch code widths
  localparam int AZMUX_W    = 4;
  localparam int PC_W       = 2;

  // status and monitor bus widths
  localparam int STATUS_W   = 3;
  localparam int MON_W      = 8;

  // precharge switch parked on the boot buffer, protects the signal
  localparam logic [PC_W-1:0]    SW_PC_BOOT     = 2'b00;

  // reset defaults of the register block
  localparam logic [CNT_W-1:0]   DEF_PRECHARGE  = 24'd16;
  // azmux hi selects the precharge output, lo selects the low reference
  localparam logic [AZMUX_W-1:0] DEF_AZMUX_HI   = 4'b1010;
  localparam logic [AZMUX_W-1:0] DEF_AZMUX_LO   = 4'b1100;
  localparam logic [PC_W-1:0]    DEF_PC_HI      = 2'b01;

endpackage

`default_nettype wire

// File: az_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

module az_cfg_regs (
  input  wire                                    clk,
  input  wire                                    reset_n,

  // plain write strobe, no handshake
  input  wire                                    cfg_we_i,
  input  az_types_pkg::az_reg_e                  cfg_addr_i,
  input  wire  [az_cfg_pkg::CFG_DATA_W-1:0]      cfg_wdata_i,

  // register fields out to the sequencer
  output logic [az_cfg_pkg::CNT_W-1:0]           precharge_cnt_o,
  output logic [az_cfg_pkg::AZMUX_W-1:0]         azmux_hi_o,
  output logic [az_cfg_pkg::AZMUX_W-1:0]         azmux_lo_o,
  output logic [az_cfg_pkg::PC_W-1:0]            pc_hi_o,
  output logic                                   run_o
);

  //////////////////////////////////////////////////
  // register write decode

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      // defaults leave the sequencer stopped
      precharge_cnt_o <= az_cfg_pkg::DEF_PRECHARGE;
      azmux_hi_o      <= az_cfg_pkg::DEF_AZMUX_HI;
      azmux_lo_o      <= az_cfg_pkg::DEF_AZMUX_LO;
      pc_hi_o         <= az_cfg_pkg::DEF_PC_HI;
      run_o           <= 1'b0;
    end
    else if (cfg_we_i)
    begin
      // each field keeps only its low bits of the write data
      case (cfg_addr_i)
        az_types_pkg::REG_PRECHARGE:
          precharge_cnt_o <= cfg_wdata_i[az_cfg_pkg::CNT_W-1:0];

        az_types_pkg::REG_AZMUX_HI:
          azmux_hi_o <= cfg_wdata_i[az_cfg_pkg::AZMUX_W-1:0];

        az_types_pkg::REG_AZMUX_LO:
          azmux_lo_o <= cfg_wdata_i[az_cfg_pkg::AZMUX_W-1:0];

        az_types_pkg::REG_PC_HI:
          pc_hi_o <= cfg_wdata_i[az_cfg_pkg::PC_W-1:0];

        // ctrl bit 0 starts and stops the sample sequence
        az_types_pkg::REG_CTRL:
          run_o <= cfg_wdata_i[0];

        // unknown address, nothing changes
        default:
        begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: az_result.sv
`timescale 1ns/10ps
`default_nettype none

module az_result (
  input  wire                                    clk,
  input  wire                                    reset_n,

  // one strobe per accepted adc measurement
  input  wire                                    sample_done_i,
  input  az_types_pkg::az_kind_e                 sample_kind_i,
  input  wire  [az_cfg_pkg::ADC_W-1:0]           adc_count_i,

  output logic signed [az_cfg_pkg::RES_W-1:0]    result_o,
  output logic                                   result_valid_o
);

  logic [az_cfg_pkg::ADC_W-1:0]  lo_count;
  logic                          lo_valid;
  logic signed [az_cfg_pkg::RES_W-1:0] az_diff;

  // counts are unsigned, one extra bit holds the sign of the difference
  assign az_diff = $signed({1'b0, adc_count_i}) - $signed({1'b0, lo_count});

  //////////////////////////////////////////////////
  // lo capture

  always_ff @(posedge clk)
  begin
    if (sample_done_i && (sample_kind_i == az_types_pkg::KIND_LO))
      lo_count <= adc_count_i;
  end

  //////////////////////////////////////////////////
  // hi minus most recent lo

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      lo_valid       <= 1'b0;
      result_valid_o <= 1'b0;
    end
    else
    begin
      result_valid_o <= 1'b0;
      if (sample_done_i && (sample_kind_i == az_types_pkg::KIND_LO))
        lo_valid <= 1'b1;
      // first hi after reset has no lo to subtract, no result
      if (sample_done_i && (sample_kind_i == az_types_pkg::KIND_HI) && lo_valid)
        result_valid_o <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample_done_i && (sample_kind_i == az_types_pkg::KIND_HI) && lo_valid)
      result_o <= az_diff;
  end

endmodule

`default_nettype wire

// File: az_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module az_sequencer (
  input  wire                                    clk,
  input  wire                                    reset_n,

  // config from the register block
  input  wire  [az_cfg_pkg::CNT_W-1:0]           precharge_cnt_i,
  input  wire  [az_cfg_pkg::AZMUX_W-1:0]         azmux_hi_i,
  input  wire  [az_cfg_pkg::AZMUX_W-1:0]         azmux_lo_i,
  input  wire  [az_cfg_pkg::PC_W-1:0]            pc_hi_i,
  input  wire                                    run_i,

  // adc control
  input  wire                                    adc_measure_valid_i,
  output logic                                   adc_reset_no,

  // analog switch controls
  output logic [az_cfg_pkg::PC_W-1:0]            sw_pc_ctl_o,
  output logic [az_cfg_pkg::AZMUX_W-1:0]         azmux_o,

  // per sample strobe to the result stage
  output logic                                   sample_done_o,
  output az_types_pkg::az_kind_e                 sample_kind_o,

  output logic [az_cfg_pkg::STATUS_W-1:0]        status_o,
  output logic                                   led0_o
);

  az_types_pkg::az_state_e       state;
  az_types_pkg::az_state_e       phase_next;
  az_types_pkg::az_state_e       phase_wait;
  logic [az_cfg_pkg::CNT_W-1:0]  settle_cnt;
  logic                          settle_zero;
  logic                          in_adc;
  logic                          adc_accept;

  // zero settle count skips the wait state entirely
  assign settle_zero = (precharge_cnt_i == '0);

  assign in_adc = (state == az_types_pkg::S_ADC_HI) || (state == az_types_pkg::S_ADC_LO);

  // a valid pulse only counts once the adc has been released
  assign adc_accept = in_adc && adc_reset_no && adc_measure_valid_i;

  assign sample_done_o = adc_accept;
  assign sample_kind_o = (state == az_types_pkg::S_ADC_HI) ? az_types_pkg::KIND_HI
                                                           : az_types_pkg::KIND_LO;

  //////////////////////////////////////////////////
  // phase table
  // entry and wait state of a phase share their successor

  always_comb
  begin
    phase_next = az_types_pkg::S_IDLE;
    phase_wait = az_types_pkg::S_IDLE;
    case (state)
      az_types_pkg::S_PC_BOOT, az_types_pkg::S_PC_BOOT_WAIT:
      begin
        phase_next = az_types_pkg::S_AZ_HI;
        phase_wait = az_types_pkg::S_PC_BOOT_WAIT;
      end
      az_types_pkg::S_AZ_HI, az_types_pkg::S_AZ_HI_WAIT:
      begin
        phase_next = az_types_pkg::S_PC_SIG;
        phase_wait = az_types_pkg::S_AZ_HI_WAIT;
      end
      az_types_pkg::S_PC_SIG, az_types_pkg::S_PC_SIG_WAIT:
      begin
        phase_next = az_types_pkg::S_ADC_HI;
        phase_wait = az_types_pkg::S_PC_SIG_WAIT;
      end
      az_types_pkg::S_PC_BACK, az_types_pkg::S_PC_BACK_WAIT:
      begin
        phase_next = az_types_pkg::S_AZ_LO;
        phase_wait = az_types_pkg::S_PC_BACK_WAIT;
      end
      az_types_pkg::S_AZ_LO, az_types_pkg::S_AZ_LO_WAIT:
      begin
        phase_next = az_types_pkg::S_ADC_LO;
        phase_wait = az_types_pkg::S_AZ_LO_WAIT;
      end
      default:
      begin
      end
    endcase
  end

  //////////////////////////////////////////////////
  // state and settle countdown

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state      <= az_types_pkg::S_IDLE;
      settle_cnt <= '0;
    end
    else
    begin
      case (state)
        // run is only looked at before a hi sample
        az_types_pkg::S_IDLE:
          if (run_i)
            state <= az_types_pkg::S_PC_BOOT;

        // entry states load the countdown
        // the entry cycle itself is the first settle cycle
        az_types_pkg::S_PC_BOOT, az_types_pkg::S_AZ_HI, az_types_pkg::S_PC_SIG,
        az_types_pkg::S_PC_BACK, az_types_pkg::S_AZ_LO:
          if (settle_zero)
            state <= phase_next;
          else
          begin
            settle_cnt <= precharge_cnt_i - 1'b1;
            state      <= phase_wait;
          end

        az_types_pkg::S_PC_BOOT_WAIT, az_types_pkg::S_AZ_HI_WAIT,
        az_types_pkg::S_PC_SIG_WAIT, az_types_pkg::S_PC_BACK_WAIT,
        az_types_pkg::S_AZ_LO_WAIT:
          if (settle_cnt == '0)
            state <= phase_next;
          else
            settle_cnt <= settle_cnt - 1'b1;

        // wait for the adc, no timeout
        az_types_pkg::S_ADC_HI:
          if (adc_accept)
            state <= az_types_pkg::S_PC_BACK;

        // a started pair always finishes here
        az_types_pkg::S_ADC_LO:
          if (adc_accept)
            state <= run_i ? az_types_pkg::S_PC_BOOT : az_types_pkg::S_IDLE;

        default:
          state <= az_types_pkg::S_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // analog switch outputs
  // azmux only ever moves while sw_pc sits on boot

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      sw_pc_ctl_o <= az_cfg_pkg::SW_PC_BOOT;
      azmux_o     <= az_cfg_pkg::DEF_AZMUX_LO;
    end
    else
    begin
      case (state)
        az_types_pkg::S_PC_BOOT, az_types_pkg::S_PC_BACK:
          sw_pc_ctl_o <= az_cfg_pkg::SW_PC_BOOT;
        // hand the signal to the precharge output
        az_types_pkg::S_PC_SIG:
          sw_pc_ctl_o <= pc_hi_i;
        az_types_pkg::S_AZ_HI:
          azmux_o <= azmux_hi_i;
        az_types_pkg::S_AZ_LO:
          azmux_o <= azmux_lo_i;
        default:
        begin
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // adc release and status

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      adc_reset_no <= 1'b0;
      status_o     <= '0;
      led0_o       <= 1'b0;
    end
    else
    begin
      // adc held out of reset for the whole adc state, back in on accept
      adc_reset_no <= in_adc && !adc_accept;

      if (adc_accept)
      begin
        if (state == az_types_pkg::S_ADC_HI)
          status_o[0] <= 1'b1;
        else
        begin
          // lo closes the pair
          status_o <= {status_o[2:1] + 2'd1, 1'b0};
          led0_o   <= !led0_o;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: az_types_pkg.sv
`default_nettype none

package az_types_pkg;

  // sequencer states
  // each settle phase is an entry state plus its wait state
  typedef enum logic [3:0] {
    S_IDLE         = 4'd0,
    S_PC_BOOT      = 4'd1,
    S_PC_BOOT_WAIT = 4'd2,
    S_AZ_HI        = 4'd3,
    S_AZ_HI_WAIT   = 4'd4,
    S_PC_SIG       = 4'd5,
    S_PC_SIG_WAIT  = 4'd6,
    S_ADC_HI       = 4'd7,
    S_PC_BACK      = 4'd8,
    S_PC_BACK_WAIT = 4'd9,
    S_AZ_LO        = 4'd10,
    S_AZ_LO_WAIT   = 4'd11,
    S_ADC_LO       = 4'd12
  } az_state_e;

  // register addresses of the config block
  typedef enum logic [2:0] {
    REG_PRECHARGE = 3'd0,
    REG_AZMUX_HI  = 3'd1,
    REG_AZMUX_LO  = 3'd2,
    REG_PC_HI     = 3'd3,
    REG_CTRL      = 3'd4
  } az_reg_e;

  // which side of the auto-zero pair a sample belongs to
  typedef enum logic {
    KIND_LO = 1'b0,
    KIND_HI = 1'b1
  } az_kind_e;

endpackage

`default_nettype wire

// File: build.f
az_cfg_pkg.sv
az_types_pkg.sv
az_cfg_regs.sv
az_sequencer.sv
az_result.sv
az_acq_top.sv
az_acq_chk.sv
az_acq_monitor.sv
tb_az_acq_top.sv

// File: tb_az_acq_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_az_acq_top;

  logic                                  clk;
  logic                                  reset_n;
  logic                                  cfg_we;
  az_types_pkg::az_reg_e                 cfg_addr;
  logic [az_cfg_pkg::CFG_DATA_W-1:0]     cfg_wdata;
  logic                                  adc_reset_n;
  logic                                  adc_valid;
  logic [az_cfg_pkg::ADC_W-1:0]          adc_count;
  logic [az_cfg_pkg::PC_W-1:0]           sw_pc;
  logic [az_cfg_pkg::AZMUX_W-1:0]        azmux;
  logic [az_cfg_pkg::STATUS_W-1:0]       status;
  logic signed [az_cfg_pkg::RES_W-1:0]   result;
  logic                                  result_valid;
  logic [az_cfg_pkg::MON_W-1:0]          monitor;

  int                                    test_id;
  logic                                  check_reset;
  logic [az_cfg_pkg::AZMUX_W-1:0]        exp_hi;
  logic [az_cfg_pkg::AZMUX_W-1:0]        exp_lo;
  logic [az_cfg_pkg::PC_W-1:0]           exp_pc;
  int                                    mon_errors;
  int                                    mon_results;
  int                                    mon_pairs;
  int                                    tb_errors;
  int                                    tests_failed;
  int                                    err_before;
  int                                    res_mark;
  logic [31:0]                           lfsr;

  always #4 clk = ~clk;

  az_acq_top i_az_acq_top (
    .clk (clk), .reset_n (reset_n),
    .cfg_we_i (cfg_we), .cfg_addr_i (cfg_addr), .cfg_wdata_i (cfg_wdata),
    .adc_reset_no (adc_reset_n), .adc_measure_valid_i (adc_valid),
    .adc_count_i (adc_count), .sw_pc_ctl_o (sw_pc), .azmux_o (azmux),
    .status_o (status), .result_o (result), .result_valid_o (result_valid),
    .monitor_o (monitor)
  );

  az_acq_monitor i_az_acq_monitor (
    .clk (clk), .reset_n (reset_n), .test_id_i (test_id),
    .check_reset_i (check_reset), .exp_azmux_hi_i (exp_hi), .exp_azmux_lo_i (exp_lo),
    .exp_pc_hi_i (exp_pc),
    .adc_reset_n_i (adc_reset_n), .adc_measure_valid_i (adc_valid),
    .adc_count_i (adc_count), .sw_pc_ctl_i (sw_pc), .azmux_i (azmux),
    .status_i (status), .result_i (result), .result_valid_i (result_valid),
    .monitor_i (monitor),
    .errors_o (mon_errors), .results_o (mon_results), .pairs_o (mon_pairs)
  );

  bind az_acq_top az_acq_chk i_az_acq_chk (
    .clk (clk), .reset_n (reset_n), .sw_pc_ctl_i (sw_pc_ctl_o), .azmux_i (azmux_o),
    .adc_reset_n_i (adc_reset_no), .adc_measure_valid_i (adc_measure_valid_i),
    .sample_done_i (sample_done), .result_valid_i (result_valid_o)
  );

  // galois lfsr, one step per bit drawn
  function automatic logic [31:0] draw_bits(input int nbits);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < nbits; i++)
    begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb)
        lfsr = lfsr ^ 32'h8020_0003;
      val = {val[30:0], lsb};
    end
    return val;
  endfunction

  task automatic finish_run(input bit ok);
    $display("tests run: 5, tests failed: %0d, check errors: %0d", tests_failed,
             mon_errors + tb_errors);
    if (ok)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    finish_run(1'b0);
  endtask

  task automatic write_reg(input az_types_pkg::az_reg_e addr, input int data);
    @(posedge clk);
    #1;
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data[az_cfg_pkg::CFG_DATA_W-1:0];
    @(posedge clk);
    #1;
    cfg_we    = 1'b0;
  endtask

  task automatic wait_results(input int n);
    int target;
    target = mon_results + n;
    for (int t = 0; mon_results < target; t++)
    begin
      if (t > 20000)
        abort_run($sformatf("timed out waiting for %0d results", n));
      else
      begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic wait_pairs(input int n);
    int target;
    target = mon_pairs + n;
    for (int t = 0; mon_pairs < target; t++)
    begin
      if (t > 20000)
        abort_run($sformatf("timed out waiting for %0d sample pairs", n));
      else
      begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  // idle once the adc has stayed in reset longer than a full settle run
  task automatic wait_idle();
    int quiet;
    quiet = 0;
    for (int t = 0; quiet < 100; t++)
    begin
      if (t > 20000)
        abort_run("sequencer did not go idle after run was cleared");
      else
      begin
        @(posedge clk);
        #1;
        quiet = adc_reset_n ? 0 : quiet + 1;
      end
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = mon_errors + tb_errors - err_before;
    if (errs == 0)
      $display("test %s done, no errors", name);
    else
    begin
      $display("test %s done, %0d errors", name, errs);
      tests_failed++;
    end
    err_before = mon_errors + tb_errors;
  endtask

  //////////////////////////////////////////////////
  // adc model

  initial
  begin
    int          lag;
    int          t;
    logic [31:0] raw;
    forever
    begin
      t = 0;
      @(posedge clk);
      // released means a clean high, not still unknown from power up
      while (adc_reset_n !== 1'b1)
      begin
        t++;
        if (t > 50000)
          abort_run("adc was never released from reset");
        else
          @(posedge clk);
      end
      // conversion time of 2 to 9 cycles
      lag = 2 + int'(draw_bits(3));
      repeat (lag - 1) @(posedge clk);
      #1;
      raw       = draw_bits(az_cfg_pkg::ADC_W);
      adc_count = raw[az_cfg_pkg::ADC_W-1:0];
      adc_valid = 1'b1;
      @(posedge clk);
      #1;
      adc_valid = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // test sequence

  initial
  begin
    clk          = 1'b0;
    reset_n      = 1'b0;
    cfg_we       = 1'b0;
    cfg_addr     = az_types_pkg::REG_PRECHARGE;
    cfg_wdata    = '0;
    adc_valid    = 1'b0;
    adc_count    = '0;
    lfsr         = 32'haf6c_dfd4;
    test_id      = 0;
    check_reset  = 1'b0;
    tb_errors    = 0;
    tests_failed = 0;
    err_before   = 0;
    exp_hi       = az_cfg_pkg::DEF_AZMUX_HI;
    exp_lo       = az_cfg_pkg::DEF_AZMUX_LO;
    exp_pc       = az_cfg_pkg::DEF_PC_HI;
    repeat (8) @(posedge clk);
    #1;
    reset_n = 1'b1;

    // reset state, nothing moves while run is clear
    test_id = 1;
    check_reset = 1'b1;
    repeat (30) @(posedge clk);
    #1;
    check_reset = 1'b0;
    end_test("reset_state");

    test_id = 2;
    write_reg(az_types_pkg::REG_CTRL, 1);
    wait_results(20);
    end_test("default_results");

    // switch codes change only while stopped
    test_id = 3;
    write_reg(az_types_pkg::REG_CTRL, 0);
    wait_idle();
    write_reg(az_types_pkg::REG_AZMUX_HI, 4'h3);
    write_reg(az_types_pkg::REG_AZMUX_LO, 4'h5);
    write_reg(az_types_pkg::REG_PC_HI, 2'b11);
    exp_hi = 4'h3;
    exp_lo = 4'h5;
    exp_pc = 2'b11;
    write_reg(az_types_pkg::REG_CTRL, 1);
    wait_results(3);
    end_test("azmux_codes");

    test_id = 4;
    wait_pairs(6);
    end_test("status_count");

    test_id = 5;
    write_reg(az_types_pkg::REG_CTRL, 0);
    wait_idle();
    res_mark = mon_results;
    repeat (150) @(posedge clk);
    #1;
    if (mon_results != res_mark)
    begin
      $display("results kept coming after run was cleared");
      tb_errors++;
    end
    write_reg(az_types_pkg::REG_CTRL, 1);
    wait_results(2);
    end_test("run_stop_resume");

    finish_run((mon_errors + tb_errors) == 0);
  end

endmodule

`default_nettype wire
